// ==== design/completion_collector.sv ====
/* Gathers tile done, error and arrival counts into round results.
   Opens a round on go and pulses round_end once when every tile is done. */
`timescale 1ns/1ps
`default_nettype none

module completion_collector #(
  parameter int num_tiles_p = 6
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             go_i,
  input  logic             done_i  [num_tiles_p],
  input  logic             err_i   [num_tiles_p],
  input  mesh_pkg::count_t count_i [num_tiles_p],
  output logic             round_end_o,
  output logic             error_o,
  output mesh_pkg::count_t rx_total_o
);
  import mesh_pkg::*;

  logic   open_r;
  logic   all_done;
  logic   any_err;
  count_t sum;

  always_comb begin
    all_done = 1'b1;
    any_err  = 1'b0;
    sum      = '0;
    for (int i = 0; i < num_tiles_p; i++) begin
      all_done = all_done & done_i[i];
      any_err  = any_err | err_i[i];
      sum      = sum + count_i[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      open_r      <= 1'b0;
      round_end_o <= 1'b0;
      error_o     <= 1'b0;
      rx_total_o  <= '0;
    end else begin
      error_o     <= any_err;
      round_end_o <= open_r && all_done;
      if (go_i) begin
        open_r <= 1'b1;
      end else if (open_r && all_done) begin
        open_r     <= 1'b0;  // One pulse per round.
        rx_total_o <= sum;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/mesh_fifo.sv ====
/* Two-entry packet buffer placed at every router input.
   Ready is simply "not full", so a full buffer back-pressures the sender. */
`timescale 1ns/1ps
`default_nettype none

module mesh_fifo (
  input  logic          clk_i,
  input  logic          reset_i,
  mesh_link_if.receiver in_i,
  mesh_link_if.sender   out_o
);
  import mesh_pkg::*;

  mesh_packet_t mem_r [2];
  logic         wr_ptr_r;
  logic         rd_ptr_r;
  logic [1:0]   count_r;
  logic         push;
  logic         pop;

  assign in_i.ready = (count_r != 2'd2);
  assign out_o.v    = (count_r != 2'd0);
  assign out_o.pkt  = mem_r[rd_ptr_r];
  assign push       = in_i.v && in_i.ready;
  assign pop        = out_o.v && out_o.ready;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= in_i.pkt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) wr_ptr_r <= ~wr_ptr_r;
      if (pop) rd_ptr_r <= ~rd_ptr_r;
      count_r <= count_r + {1'b0, push} - {1'b0, pop};
    end
  end

  // A packet stalled on a full buffer must still be offered next cycle.
  a_hold_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    in_i.v && !in_i.ready |=> in_i.v && $stable(in_i.pkt));

endmodule

`default_nettype wire

// ==== design/mesh_link_if.sv ====
/* One directional router link with a valid/ready handshake.
   The sender keeps v and pkt steady until a cycle with ready high. */
`timescale 1ns/1ps
`default_nettype none

interface mesh_link_if;
  import mesh_pkg::*;

  logic         v;
  logic         ready;
  mesh_packet_t pkt;

  modport sender (
    output v,
    output pkt,
    input  ready
  );

  modport receiver (
    input  v,
    input  pkt,
    output ready
  );

endinterface

`default_nettype wire

// ==== design/mesh_pkg.sv ====
/* Shared types for the mesh all-to-all test: coordinates, tags, packets, enums.
   Imported by the link interface and every design module. */
`default_nettype none

package mesh_pkg;

  localparam int coord_width_c = 3;  // Up to an 8 by 8 mesh.

  typedef logic [coord_width_c-1:0] coord_t;
  typedef logic [7:0]               tag_t;
  typedef logic [7:0]               src_id_t;  // y * width + x.
  typedef logic [15:0]              count_t;

  typedef struct packed {
    coord_t  dst_x;
    coord_t  dst_y;
    src_id_t src_id;
    tag_t    tag;
  } mesh_packet_t;

  // Router port slots, also the index into the link arrays.
  typedef enum logic [2:0] {
    dir_p    = 3'd0,
    dir_w    = 3'd1,
    dir_east = 3'd2,
    dir_n    = 3'd3,
    dir_s    = 3'd4
  } dir_e;

  typedef enum logic {
    st_idle,
    st_busy
  } launch_state_e;

endpackage

`default_nettype wire

// ==== design/mesh_router.sv ====
/* Five-port buffered mesh router with X-then-Y routing.
   Each output grants one requesting input per cycle, round-robin. */
`timescale 1ns/1ps
`default_nettype none

module mesh_router #(
  parameter int num_x_p = 3,
  parameter int num_y_p = 2
) (
  input  logic             clk_i,
  input  logic             reset_i,
  mesh_link_if.receiver    link_in_i [5],
  mesh_link_if.sender      link_out_o [5],
  input  mesh_pkg::coord_t my_x_i,
  input  mesh_pkg::coord_t my_y_i
);
  import mesh_pkg::*;

  localparam int ports_lp = 5;

  mesh_link_if fifo_q [ports_lp] ();

  logic                head_v    [ports_lp];
  mesh_packet_t        head_pkt  [ports_lp];
  logic                head_deq  [ports_lp];
  dir_e                route     [ports_lp];
  logic [ports_lp-1:0] req       [ports_lp];  // Indexed [output][input].
  logic [ports_lp-1:0] gnt       [ports_lp];
  logic                out_v     [ports_lp];
  logic                out_ready [ports_lp];
  mesh_packet_t        out_pkt   [ports_lp];
  logic [2:0]          rr_r      [ports_lp];  // Last granted input.

  for (genvar p = 0; p < ports_lp; p++) begin : g_port
    mesh_fifo fifo_i (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .in_i    (link_in_i[p]),
      .out_o   (fifo_q[p])
    );

    assign head_v[p]         = fifo_q[p].v;
    assign head_pkt[p]       = fifo_q[p].pkt;
    assign fifo_q[p].ready   = head_deq[p];
    assign link_out_o[p].v   = out_v[p];
    assign link_out_o[p].pkt = out_pkt[p];
    assign out_ready[p]      = link_out_o[p].ready;
  end

  // X first, then Y, then eject.
  always_comb begin
    for (int o = 0; o < ports_lp; o++) begin
      req[o] = '0;
    end
    for (int i = 0; i < ports_lp; i++) begin
      if (head_pkt[i].dst_x > my_x_i) begin
        route[i] = dir_east;
      end else if (head_pkt[i].dst_x < my_x_i) begin
        route[i] = dir_w;
      end else if (head_pkt[i].dst_y > my_y_i) begin
        route[i] = dir_s;
      end else if (head_pkt[i].dst_y < my_y_i) begin
        route[i] = dir_n;
      end else begin
        route[i] = dir_p;
      end
      req[route[i]][i] = head_v[i];
    end
  end

  always_comb begin
    int idx;
    for (int o = 0; o < ports_lp; o++) begin
      gnt[o]     = '0;
      out_v[o]   = 1'b0;
      out_pkt[o] = '0;
      // Search starts just past the last winner.
      for (int k = 1; k <= ports_lp; k++) begin
        idx = (int'(rr_r[o]) + k) % ports_lp;
        if (!out_v[o] && req[o][idx]) begin
          gnt[o][idx] = 1'b1;
          out_v[o]    = 1'b1;
          out_pkt[o]  = head_pkt[idx];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < ports_lp; i++) begin
      head_deq[i] = 1'b0;
      for (int o = 0; o < ports_lp; o++) begin
        if (gnt[o][i] && out_ready[o]) head_deq[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int o = 0; o < ports_lp; o++) begin
        rr_r[o] <= 3'd4;  // Input 0 wins first.
      end
    end else begin
      for (int o = 0; o < ports_lp; o++) begin
        for (int i = 0; i < ports_lp; i++) begin
          if (gnt[o][i] && out_ready[o]) begin
            rr_r[o] <= 3'(i);
          end else if (gnt[o][i]) begin
            // Stalled winner is searched first, so v and pkt hold.
            rr_r[o] <= 3'((i + ports_lp - 1) % ports_lp);
          end
        end
      end
    end
  end

  // Destinations from the tiles never point off the mesh.
  a_no_border: assert property (@(posedge clk_i) disable iff (reset_i)
    !(out_v[dir_w] && my_x_i == '0) &&
    !(out_v[dir_east] && my_x_i == coord_t'(num_x_p - 1)) &&
    !(out_v[dir_n] && my_y_i == '0) &&
    !(out_v[dir_s] && my_y_i == coord_t'(num_y_p - 1)));

endmodule

`default_nettype wire

// ==== design/mesh_tile.sv ====
/* One mesh tile: router, all-to-all packet sender and arrival tracker.
   Go restarts sending and clears arrivals; done rises once every source is seen. */
`timescale 1ns/1ps
`default_nettype none

module mesh_tile #(
  parameter int num_x_p = 3,
  parameter int num_y_p = 2
) (
  input  logic             clk_i,
  input  logic             reset_i,
  mesh_link_if.receiver    in_w_i,
  mesh_link_if.receiver    in_e_i,
  mesh_link_if.receiver    in_n_i,
  mesh_link_if.receiver    in_s_i,
  mesh_link_if.sender      out_w_o,
  mesh_link_if.sender      out_e_o,
  mesh_link_if.sender      out_n_o,
  mesh_link_if.sender      out_s_o,
  input  mesh_pkg::coord_t my_x_i,
  input  mesh_pkg::coord_t my_y_i,
  input  logic             go_i,
  input  mesh_pkg::tag_t   tag_i,
  output logic             done_o,
  output logic             err_o,
  output mesh_pkg::count_t rx_count_o
);
  import mesh_pkg::*;

  localparam int num_tiles_lp = num_x_p * num_y_p;

  mesh_link_if rtr_in  [5] ();
  mesh_link_if rtr_out [5] ();

  src_id_t                 my_id;
  coord_t                  dst_x_r;
  coord_t                  dst_y_r;
  logic                    send_r;
  logic                    send_ready;
  logic                    row_end;
  logic                    rx_v;
  mesh_packet_t            rx_pkt;
  logic                    rx_dup;
  logic                    rx_bad;
  logic [num_tiles_lp-1:0] seen_r;

  mesh_router #(.num_x_p(num_x_p), .num_y_p(num_y_p)) router_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .link_in_i  (rtr_in),
    .link_out_o (rtr_out),
    .my_x_i     (my_x_i),
    .my_y_i     (my_y_i)
  );

  // Neighbour links into the router's direction slots.
  assign rtr_in[dir_w].v          = in_w_i.v;
  assign rtr_in[dir_w].pkt        = in_w_i.pkt;
  assign in_w_i.ready             = rtr_in[dir_w].ready;
  assign rtr_in[dir_east].v       = in_e_i.v;
  assign rtr_in[dir_east].pkt     = in_e_i.pkt;
  assign in_e_i.ready             = rtr_in[dir_east].ready;
  assign rtr_in[dir_n].v          = in_n_i.v;
  assign rtr_in[dir_n].pkt        = in_n_i.pkt;
  assign in_n_i.ready             = rtr_in[dir_n].ready;
  assign rtr_in[dir_s].v          = in_s_i.v;
  assign rtr_in[dir_s].pkt        = in_s_i.pkt;
  assign in_s_i.ready             = rtr_in[dir_s].ready;
  assign out_w_o.v                = rtr_out[dir_w].v;
  assign out_w_o.pkt              = rtr_out[dir_w].pkt;
  assign rtr_out[dir_w].ready     = out_w_o.ready;
  assign out_e_o.v                = rtr_out[dir_east].v;
  assign out_e_o.pkt              = rtr_out[dir_east].pkt;
  assign rtr_out[dir_east].ready  = out_e_o.ready;
  assign out_n_o.v                = rtr_out[dir_n].v;
  assign out_n_o.pkt              = rtr_out[dir_n].pkt;
  assign rtr_out[dir_n].ready     = out_n_o.ready;
  assign out_s_o.v                = rtr_out[dir_s].v;
  assign out_s_o.pkt              = rtr_out[dir_s].pkt;
  assign rtr_out[dir_s].ready     = out_s_o.ready;

  assign my_id = src_id_t'(int'(my_y_i) * num_x_p + int'(my_x_i));

  // Sender walks (0,0) to the last tile in row-major order.
  assign rtr_in[dir_p].v   = send_r;
  assign rtr_in[dir_p].pkt = '{dst_x: dst_x_r, dst_y: dst_y_r, src_id: my_id, tag: tag_i};
  assign send_ready        = rtr_in[dir_p].ready;
  assign row_end           = (dst_x_r == coord_t'(num_x_p - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_r  <= 1'b0;
      dst_x_r <= '0;
      dst_y_r <= '0;
    end else if (go_i) begin
      send_r  <= 1'b1;
      dst_x_r <= '0;
      dst_y_r <= '0;
    end else if (send_r && send_ready) begin
      dst_x_r <= row_end ? '0 : dst_x_r + 1'b1;
      if (row_end) dst_y_r <= dst_y_r + 1'b1;
      if (row_end && dst_y_r == coord_t'(num_y_p - 1)) send_r <= 1'b0;
    end
  end

  assign rx_v                 = rtr_out[dir_p].v;
  assign rx_pkt               = rtr_out[dir_p].pkt;
  assign rtr_out[dir_p].ready = 1'b1;  // Always sinks.

  always_comb begin
    rx_dup = 1'b0;
    for (int i = 0; i < num_tiles_lp; i++) begin
      if (int'(rx_pkt.src_id) == i && seen_r[i]) rx_dup = 1'b1;
    end
  end

  assign rx_bad = rx_dup || rx_pkt.tag != tag_i || int'(rx_pkt.src_id) >= num_tiles_lp ||
                  rx_pkt.dst_x != my_x_i || rx_pkt.dst_y != my_y_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      seen_r     <= '0;
      rx_count_o <= '0;
      err_o      <= 1'b0;
    end else if (go_i) begin
      seen_r     <= '0;
      rx_count_o <= '0;
    end else if (rx_v) begin
      rx_count_o <= rx_count_o + count_t'(1);
      for (int i = 0; i < num_tiles_lp; i++) begin
        if (int'(rx_pkt.src_id) == i) seen_r[i] <= 1'b1;
      end
      if (rx_bad) err_o <= 1'b1;  // Sticky.
    end
  end

  assign done_o = &seen_r;

  a_eject_dest: assert property (@(posedge clk_i) disable iff (reset_i)
    rx_v |-> rx_pkt.dst_x == my_x_i && rx_pkt.dst_y == my_y_i);

endmodule

`default_nettype wire

// ==== design/mesh_top.sv ====
/* Top of the mesh all-to-all test: launcher, grid of tiles and collector.
   Border links are tied off here. */
`timescale 1ns/1ps
`default_nettype none

module mesh_top #(
  parameter int num_x_p = 3,
  parameter int num_y_p = 2
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        start_i,
  input  logic [7:0]  tag_i,
  output logic        busy_o,
  output logic        done_o,
  output logic        error_o,
  output logic [15:0] rx_total_o
);
  import mesh_pkg::*;

  localparam int num_tiles_lp = num_x_p * num_y_p;
  localparam int ew_links_lp  = num_y_p * (num_x_p + 1) * 2;  // Pairs per column boundary.
  localparam int ns_links_lp  = num_x_p * (num_y_p + 1) * 2;  // Pairs per row boundary.

  // Even index goes east or south, odd goes west or north.
  mesh_link_if ew_link [ew_links_lp] ();
  mesh_link_if ns_link [ns_links_lp] ();

  logic   go;
  logic   round_end;
  tag_t   round_tag;
  logic   tile_done  [num_tiles_lp];
  logic   tile_err   [num_tiles_lp];
  count_t tile_count [num_tiles_lp];

  round_launcher launcher_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (start_i),
    .tag_i       (tag_i),
    .round_end_i (round_end),
    .go_o        (go),
    .tag_o       (round_tag),
    .busy_o      (busy_o)
  );

  for (genvar y = 0; y < num_y_p; y++) begin : g_ew_edge
    localparam int west_lp = y * (num_x_p + 1) * 2;
    localparam int east_lp = (y * (num_x_p + 1) + num_x_p) * 2;
    assign ew_link[west_lp].v         = 1'b0;
    assign ew_link[west_lp].pkt       = '0;
    assign ew_link[west_lp + 1].ready = 1'b1;
    assign ew_link[east_lp + 1].v     = 1'b0;
    assign ew_link[east_lp + 1].pkt   = '0;
    assign ew_link[east_lp].ready     = 1'b1;
  end

  for (genvar x = 0; x < num_x_p; x++) begin : g_ns_edge
    localparam int north_lp = x * 2;
    localparam int south_lp = (num_y_p * num_x_p + x) * 2;
    assign ns_link[north_lp].v         = 1'b0;
    assign ns_link[north_lp].pkt       = '0;
    assign ns_link[north_lp + 1].ready = 1'b1;
    assign ns_link[south_lp + 1].v     = 1'b0;
    assign ns_link[south_lp + 1].pkt   = '0;
    assign ns_link[south_lp].ready     = 1'b1;
  end

  for (genvar y = 0; y < num_y_p; y++) begin : g_row
    for (genvar x = 0; x < num_x_p; x++) begin : g_col
      localparam int id_lp = y * num_x_p + x;
      localparam int wb_lp = (y * (num_x_p + 1) + x) * 2;  // West boundary pair.
      localparam int eb_lp = wb_lp + 2;
      localparam int nb_lp = (y * num_x_p + x) * 2;        // North boundary pair.
      localparam int sb_lp = nb_lp + num_x_p * 2;

      mesh_tile #(.num_x_p(num_x_p), .num_y_p(num_y_p)) tile_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .in_w_i     (ew_link[wb_lp]),
        .in_e_i     (ew_link[eb_lp + 1]),
        .in_n_i     (ns_link[nb_lp]),
        .in_s_i     (ns_link[sb_lp + 1]),
        .out_w_o    (ew_link[wb_lp + 1]),
        .out_e_o    (ew_link[eb_lp]),
        .out_n_o    (ns_link[nb_lp + 1]),
        .out_s_o    (ns_link[sb_lp]),
        .my_x_i     (coord_t'(x)),
        .my_y_i     (coord_t'(y)),
        .go_i       (go),
        .tag_i      (round_tag),
        .done_o     (tile_done[id_lp]),
        .err_o      (tile_err[id_lp]),
        .rx_count_o (tile_count[id_lp])
      );
    end
  end

  completion_collector #(.num_tiles_p(num_tiles_lp)) collector_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .go_i        (go),
    .done_i      (tile_done),
    .err_i       (tile_err),
    .count_i     (tile_count),
    .round_end_o (round_end),
    .error_o     (error_o),
    .rx_total_o  (rx_total_o)
  );

  assign done_o = round_end;

endmodule

`default_nettype wire

// ==== design/round_launcher.sv ====
/* Round control: accepts start while idle, latches the tag and pulses go.
   Busy stays high until the collector reports the end of the round. */
`timescale 1ns/1ps
`default_nettype none

module round_launcher (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           start_i,
  input  mesh_pkg::tag_t tag_i,
  input  logic           round_end_i,
  output logic           go_o,
  output mesh_pkg::tag_t tag_o,
  output logic           busy_o
);
  import mesh_pkg::*;

  launch_state_e state_r;
  logic          accept;

  assign busy_o = (state_r == st_busy) && !round_end_i;  // Drops with the done pulse.
  assign accept = start_i && !busy_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle;
      go_o    <= 1'b0;
    end else begin
      go_o <= accept;
      case (state_r)
        st_idle: if (accept) state_r <= st_busy;
        st_busy: if (round_end_i && !accept) state_r <= st_idle;
        default: state_r <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) tag_o <= tag_i;
  end

  // One go pulse per round, never a second one while it runs.
  a_single_go: assert property (@(posedge clk_i) disable iff (reset_i)
    go_o |=> !go_o);

endmodule

`default_nettype wire

// ==== filelist.f ====
design/mesh_pkg.sv
design/mesh_link_if.sv
design/mesh_fifo.sv
design/mesh_router.sv
design/mesh_tile.sv
design/round_launcher.sv
design/completion_collector.sv
design/mesh_top.sv
tb/mesh_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the mesh testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module mesh_tb \
  --Mdir "$build_dir" \
  -f filelist.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$build_dir/Vmesh_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Everything OK$" "$log_file"; then
  echo "Simulation passed"
  exit 0
fi

echo "Pass message not found in $log_file"
exit 1

// ==== tb/mesh_tb.sv ====
/* Directed testbench for the mesh all-to-all top level at 3 by 2 tiles.
   Covers reset state, a single round, an ignored start and back-to-back rounds. */
`timescale 1ns/1ps
`default_nettype none

module mesh_tb;
  import mesh_pkg::*;

  localparam int     num_x_lp      = 3;
  localparam int     num_y_lp      = 2;
  localparam int     num_tiles_lp  = num_x_lp * num_y_lp;
  localparam count_t total_lp      = count_t'(num_tiles_lp * num_tiles_lp);  // All-to-all.
  localparam int     timeout_lp    = 2000;
  localparam int     idle_cycles_lp = 20;
  localparam int     num_rounds_lp = 5;

  logic   clk_i;
  logic   reset_i;
  logic   start_i;
  tag_t   tag_i;
  logic   busy_o;
  logic   done_o;
  logic   error_o;
  count_t rx_total_o;
  integer seed;

  mesh_top #(.num_x_p(num_x_lp), .num_y_p(num_y_lp)) dut_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .start_i    (start_i),
    .tag_i      (tag_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .error_o    (error_o),
    .rx_total_o (rx_total_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_with_error($sformatf("Fail %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input count_t expected, input count_t actual);
    if (actual !== expected) begin
      stop_with_error($sformatf("Fail %s: expected %h, got %h", name, expected, actual));
    end
  endtask

  // Called on a falling edge; returns on the falling edge after acceptance.
  task automatic start_round(input tag_t tag);
    start_i = 1'b1;
    tag_i   = tag;
    @(negedge clk_i);
    start_i = 1'b0;
    check_bit("busy_o", 1'b1, busy_o);  // Rises the cycle after acceptance.
    check_bit("done_o", 1'b0, done_o);
  endtask

  task automatic wait_for_done(input string what);
    int cycles;
    cycles = 0;
    while (done_o !== 1'b1) begin
      if (cycles >= timeout_lp) begin
        stop_with_error($sformatf("Timed out waiting for done_o in %s.", what));
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  // Results that must hold in the done cycle of every round.
  task automatic check_round_end();
    check_bit("done_o", 1'b1, done_o);
    check_bit("busy_o", 1'b0, busy_o);
    check_bit("error_o", 1'b0, error_o);
    check_count("rx_total_o", total_lp, rx_total_o);
  endtask

  task automatic idle_after_reset();
    check_bit("busy_o", 1'b0, busy_o);
    check_bit("done_o", 1'b0, done_o);
    check_bit("error_o", 1'b0, error_o);
  endtask

  task automatic single_round();
    start_round(8'h5a);
    wait_for_done("the single round");
    check_round_end();
    @(negedge clk_i);
    check_bit("done_o", 1'b0, done_o);  // One-cycle pulse.
    check_bit("busy_o", 1'b0, busy_o);
    check_count("rx_total_o", total_lp, rx_total_o);
  endtask

  task automatic ignored_start();
    start_round(8'h3c);
    start_i = 1'b1;  // New tag while busy, must be dropped.
    tag_i   = 8'hc3;
    @(negedge clk_i);
    start_i = 1'b0;
    wait_for_done("the ignored start round");
    check_round_end();
    repeat (idle_cycles_lp) begin
      @(negedge clk_i);
      check_bit("done_o", 1'b0, done_o);
      check_bit("busy_o", 1'b0, busy_o);
    end
    check_bit("error_o", 1'b0, error_o);
  endtask

  task automatic back_to_back_rounds();
    tag_t tag;
    for (int r = 0; r < num_rounds_lp; r++) begin
      tag = tag_t'($random(seed));
      start_round(tag);  // Lands in the done cycle of the last round.
      wait_for_done($sformatf("back-to-back round %0d", r));
      check_round_end();
    end
    @(negedge clk_i);
    check_bit("done_o", 1'b0, done_o);
  endtask

  task automatic quiet_after_rounds();
    check_bit("error_o", 1'b0, error_o);
    check_bit("busy_o", 1'b0, busy_o);
    repeat (idle_cycles_lp) begin
      @(negedge clk_i);
      check_bit("done_o", 1'b0, done_o);
      check_bit("busy_o", 1'b0, busy_o);
    end
    check_bit("error_o", 1'b0, error_o);
  endtask

  initial begin
    seed    = 32'h28fc;
    reset_i = 1'b1;
    start_i = 1'b0;
    tag_i   = '0;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    idle_after_reset();
    single_round();
    ignored_start();
    back_to_back_rounds();
    quiet_after_rounds();

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
